/* src.f */
+incdir+include
hdl/rq_pkg.sv
hdl/rq_shift_plan.sv
hdl/rq_product_pipe.sv
hdl/rq_round_clip.sv
hdl/rq_scale_top.sv
verif/rq_scale_props.sv
verif/rq_scale_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rq_scale_tb -f src.f -o rq_scale_sim
./obj_dir/rq_scale_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a pass"
    exit 1
fi
echo "simulation passed"

/* verif/rq_scale_tb.sv */
// requantization stage testbench
`timescale 1ns/1ns
`include "rq_cfg.svh"

module rq_scale_tb;

    import rq_pkg::*;

    localparam int NROWS           = 24;
    localparam int HAND_ROWS       = 10;
    localparam int WATCHDOG_CYCLES = NROWS * 6 + 50;

    logic      clk = 1'b0;
    logic      rst_n;
    acc_vec_t  acc_in;
    coef_vec_t coef_in;
    frac_t     frac_n;
    logic      in_valid;
    out_vec_t  res_out;
    logic      res_valid;

    // stimulus table, one frame per row
    acc_vec_t  tbl_acc  [NROWS];
    coef_vec_t tbl_coef [NROWS];
    frac_t     tbl_n    [NROWS];
    int        tbl_gap  [NROWS];

    out_vec_t   exp_q[$];
    out_vec_t   last_out;
    logic [2:0] vhist;
    int         checked;
    int         seed;

    rq_scale_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_in    (acc_in),
        .coef_in   (coef_in),
        .frac_n    (frac_n),
        .in_valid  (in_valid),
        .res_out   (res_out),
        .res_valid (res_valid)
    );

    always #20 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_out(out_vec_t got, out_vec_t exp, string what);
        for (int i = 0; i < `RQ_LANES; i++) begin
            if (got[i] !== exp[i]) begin
                report_failure($sformatf("Fail at %0t ns: %s lane %0d got %0d expected %0d",
                                         $time, what, i, got[i], exp[i]));
            end
        end
    endtask

    task automatic check_valid(logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t ns: res_valid got %0b expected %0b",
                                     $time, got, exp));
        end
    endtask

    // window, shift, round half up, saturate
    function automatic out_vec_t expected_result(acc_vec_t a, coef_vec_t c, frac_t n);
        out_vec_t r;
        acc_t     lane_acc;
        coef_t    lane_coef;
        int       av;
        int       win;
        int       ofs;
        int       sh;
        int       p;
        int       v;
        for (int i = 0; i < `RQ_LANES; i++) begin
            lane_acc  = a[i];
            lane_coef = c[i];
            av = int'(lane_acc);
            if (av >= -(1 << `RQ_HI_OFS) && av < (1 << `RQ_HI_OFS)) begin
                win = int'($signed(lane_acc[16:8]));
                ofs = `RQ_LO_OFS;
            end else begin
                win = int'($signed(lane_acc[21:13]));
                ofs = `RQ_HI_OFS;
            end
            sh = int'(n) - ofs;
            if (sh < 0) sh = 0;
            if (sh > 15) sh = 15;
            p = win * int'(lane_coef);
            if (sh == 0) begin
                v = p;
            end else begin
                v = (p >>> sh) + ((p >>> (sh - 1)) & 1);
            end
            if (v > 127) v = 127;
            if (v < -128) v = -128;
            r[i] = out_t'(v);
        end
        return r;
    endfunction

    // lane i gets a0 + i*da and c0 - i*dc
    task automatic fill_row(int idx, int a0, int da, int c0, int dc, int n, int gap);
        for (int i = 0; i < `RQ_LANES; i++) begin
            tbl_acc[idx][i]  = acc_t'(a0 + i * da);
            tbl_coef[idx][i] = coef_t'(c0 - i * dc);
        end
        tbl_n[idx]   = frac_t'(n);
        tbl_gap[idx] = gap;
    endtask

    task automatic build_table();
        fill_row(0, 1000, -450, 37, 15, 12, 0);
        fill_row(1, -3000, 1300, -100, -30, 10, 0);
        fill_row(2, 1500000, 100000, 200, 5, 14, 2);
        fill_row(3, -2000000, 50000, 250, 0, 16, 1);
        // exact halves
        fill_row(4, 1280, -512, 1, 0, 9, 0);
        fill_row(5, 768, -512, 2, 0, 10, 1);
        // shift clamped at both ends
        fill_row(6, 2560, -1024, 11, 2, 3, 3);
        fill_row(7, 1800000, -700000, 255, 100, 31, 0);
        fill_row(8, 8000, -3000, -256, -100, 31, 0);
        fill_row(9, -60000, 25000, 3, 1, 0, 4);
        for (int r = HAND_ROWS; r < NROWS; r++) begin
            for (int i = 0; i < `RQ_LANES; i++) begin
                tbl_acc[r][i]  = acc_t'($random(seed) >>> ($unsigned($random(seed)) % 18));
                tbl_coef[r][i] = coef_t'($random(seed));
            end
            tbl_n[r]   = frac_t'($random(seed));
            tbl_gap[r] = int'($unsigned($random(seed)) % 3);
        end
    endtask

    // in_valid history, bit 2 is the frame due out now
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vhist <= '0;
        end else begin
            vhist <= {vhist[1:0], in_valid};
        end
    end

    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            report_failure($sformatf("an assertion on the DUT failed before %0t ns", $time));
        end
        check_valid(res_valid, vhist[2]);
        if (res_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("res_valid pulsed with no frame pending");
            end else begin
                check_out(res_out, exp_q.pop_front(), $sformatf("frame %0d", checked));
                last_out = res_out;
                checked++;
            end
        end else begin
            check_out(res_out, last_out, "held result");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("simulation timed out after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        rst_n    = 1'b1;
        acc_in   = '0;
        coef_in  = '0;
        frac_n   = '0;
        in_valid = 1'b0;
        last_out = '0;
        checked  = 0;
        seed     = 32'h6592;
        build_table();
        #5 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        for (int r = 0; r < NROWS; r++) begin
            @(negedge clk);
            acc_in   = tbl_acc[r];
            coef_in  = tbl_coef[r];
            frac_n   = tbl_n[r];
            in_valid = 1'b1;
            exp_q.push_back(expected_result(tbl_acc[r], tbl_coef[r], tbl_n[r]));
            repeat (tbl_gap[r]) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        while (checked < NROWS) @(posedge clk);
        // a few idle cycles to watch the hold
        repeat (4) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

/* verif/rq_scale_props.sv */
// valid timing and reset checks
`timescale 1ns/1ns

module rq_scale_props (
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             res_valid,
    input rq_pkg::out_vec_t res_out
);

    int unsigned fail_count = 0;

    // three stages from strobe to pulse
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid == $past(in_valid, 3))
        else begin
            fail_count++;
            $error("res_valid does not follow in_valid by three cycles");
        end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !res_valid)
        else begin
            fail_count++;
            $error("res_valid high during reset");
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !res_valid |-> $stable(res_out))
        else begin
            fail_count++;
            $error("res_out changed without res_valid");
        end

endmodule

bind rq_scale_top rq_scale_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .res_valid (res_valid),
    .res_out   (res_out)
);

/* hdl/rq_scale_top.sv */
// requantization stage top
`timescale 1ns/1ns

module rq_scale_top (
    input  logic              clk,
    input  logic              rst_n,
    input  rq_pkg::acc_vec_t  acc_in,
    input  rq_pkg::coef_vec_t coef_in,
    input  rq_pkg::frac_t     frac_n,
    input  logic              in_valid,
    output rq_pkg::out_vec_t  res_out,
    output logic              res_valid
);

    import rq_pkg::*;

    sel_vec_t   win_sel;
    shift_vec_t shift_d2;
    logic       valid_d2;
    prod_vec_t  prod;

    // window choice and shift count, two cycles deep
    rq_shift_plan u_shift_plan (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_in   (acc_in),
        .frac_n   (frac_n),
        .in_valid (in_valid),
        .win_sel  (win_sel),
        .shift_d2 (shift_d2),
        .valid_d2 (valid_d2)
    );

    rq_product_pipe u_product_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .acc_in  (acc_in),
        .coef_in (coef_in),
        .win_sel (win_sel),
        .prod    (prod)
    );

    // third cycle
    rq_round_clip u_round_clip (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod      (prod),
        .shift_d2  (shift_d2),
        .valid_d2  (valid_d2),
        .res_out   (res_out),
        .res_valid (res_valid)
    );

endmodule

/* hdl/rq_round_clip.sv */
// shift, round and saturate
`timescale 1ns/1ns
`include "rq_cfg.svh"

module rq_round_clip (
    input  logic               clk,
    input  logic               rst_n,
    input  rq_pkg::prod_vec_t  prod,
    input  rq_pkg::shift_vec_t shift_d2,
    input  logic               valid_d2,
    output rq_pkg::out_vec_t   res_out,
    output logic               res_valid
);

    import rq_pkg::*;

    // one extra bit so the rounding carry cannot wrap
    localparam int SUM_W = `RQ_PROD_W + 1;

    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((1 << (`RQ_OUT_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = ~SAT_MAX;

    out_vec_t res_next;

    for (genvar i = 0; i < `RQ_LANES; i++) begin : g_lane
        prod_t                   p;
        shift_t                  s;
        prod_t                   shifted;
        logic                    round_bit;
        logic signed [SUM_W-1:0] sum;
        out_t                    clipped;

        assign p = prod[i];
        assign s = shift_d2[i];

        assign shifted = p >>> s;

        // half up: add the last bit shifted out
        assign round_bit = (s != '0) ? p[s - 1'b1] : 1'b0;

        assign sum = $signed({shifted[`RQ_PROD_W-1], shifted})
                   + $signed({{`RQ_PROD_W{1'b0}}, round_bit});

        always_comb begin
            if (sum > SAT_MAX) begin
                clipped = SAT_MAX[`RQ_OUT_W-1:0];
            end else if (sum < SAT_MIN) begin
                clipped = SAT_MIN[`RQ_OUT_W-1:0];
            end else begin
                clipped = sum[`RQ_OUT_W-1:0];
            end
        end

        assign res_next[i] = clipped;
    end

    // result holds between frames
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_out   <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= valid_d2;
            if (valid_d2) begin
                res_out <= res_next;
            end
        end
    end

endmodule

/* hdl/rq_product_pipe.sv */
// windowed multiply pipeline
`timescale 1ns/1ns
`include "rq_cfg.svh"

module rq_product_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  rq_pkg::acc_vec_t  acc_in,
    input  rq_pkg::coef_vec_t coef_in,
    input  rq_pkg::sel_vec_t  win_sel,
    output rq_pkg::prod_vec_t prod
);

    import rq_pkg::*;

    coef_vec_t win_now;
    coef_vec_t win_q;
    coef_vec_t coef_q;
    prod_vec_t prod_now;

    for (genvar i = 0; i < `RQ_LANES; i++) begin : g_lane
        acc_t  acc;
        coef_t win_lo;
        coef_t win_hi;
        coef_t op_a;
        coef_t op_b;
        prod_t lane_prod;

        assign acc = acc_in[i];

        // bits 16..8 or 21..13
        assign win_lo = acc[`RQ_LO_OFS +: `RQ_COEF_W];
        assign win_hi = acc[`RQ_HI_OFS +: `RQ_COEF_W];

        assign win_now[i] = win_sel[i] ? win_hi : win_lo;

        // signed locals keep the multiply signed
        assign op_a      = win_q[i];
        assign op_b      = coef_q[i];
        assign lane_prod = op_a * op_b;

        assign prod_now[i] = lane_prod;
    end

    // operand stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_q  <= '0;
            coef_q <= '0;
        end else begin
            win_q  <= win_now;
            coef_q <= coef_in;
        end
    end

    // product stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod <= '0;
        end else begin
            prod <= prod_now;
        end
    end

endmodule

/* hdl/rq_shift_plan.sv */
// window choice and shift planning
`timescale 1ns/1ns
`include "rq_cfg.svh"

module rq_shift_plan (
    input  logic               clk,
    input  logic               rst_n,
    input  rq_pkg::acc_vec_t   acc_in,
    input  rq_pkg::frac_t      frac_n,
    input  logic               in_valid,
    output rq_pkg::sel_vec_t   win_sel,
    output rq_pkg::shift_vec_t shift_d2,
    output logic               valid_d2
);

    import rq_pkg::*;

    // two guard bits so n minus offset stays signed
    localparam int DIFF_W = `RQ_FRAC_W + 2;

    localparam logic signed [DIFF_W-1:0] LO_OFS    = DIFF_W'(`RQ_LO_OFS);
    localparam logic signed [DIFF_W-1:0] HI_OFS    = DIFF_W'(`RQ_HI_OFS);
    localparam logic signed [DIFF_W-1:0] SHIFT_MAX = DIFF_W'((1 << `RQ_SHIFT_W) - 1);

    shift_vec_t shift_now;
    shift_vec_t shift_d1;
    logic       valid_d1;

    for (genvar i = 0; i < `RQ_LANES; i++) begin : g_lane
        acc_t                     acc;
        logic                     hi_sel;
        logic signed [DIFF_W-1:0] diff;
        shift_t                   lane_shift;

        assign acc = acc_in[i];

        // low window is safe only if the top bits are pure sign extension
        assign hi_sel = (acc[`RQ_HI_OFS +: `RQ_COEF_W] != {`RQ_COEF_W{acc[`RQ_ACC_W-1]}});

        assign diff = $signed({2'b00, frac_n}) - (hi_sel ? HI_OFS : LO_OFS);

        // clamp to 0..15
        always_comb begin
            if (diff < 0) begin
                lane_shift = '0;
            end else if (diff > SHIFT_MAX) begin
                lane_shift = '1;
            end else begin
                lane_shift = diff[`RQ_SHIFT_W-1:0];
            end
        end

        assign win_sel[i]   = hi_sel;
        assign shift_now[i] = lane_shift;
    end

    // delay to line up with the product pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_d1 <= '0;
            shift_d2 <= '0;
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            shift_d1 <= shift_now;
            shift_d2 <= shift_d1;
            valid_d1 <= in_valid;
            valid_d2 <= valid_d1;
        end
    end

endmodule

/* hdl/rq_pkg.sv */
// requantization types
`include "rq_cfg.svh"

package rq_pkg;

    // per-lane scalars, signed datapath
    typedef logic signed [`RQ_ACC_W-1:0]  acc_t;
    typedef logic signed [`RQ_COEF_W-1:0] coef_t;
    typedef logic signed [`RQ_PROD_W-1:0] prod_t;
    typedef logic signed [`RQ_OUT_W-1:0]  out_t;

    // shift count and fraction position are plain magnitudes
    typedef logic [`RQ_SHIFT_W-1:0] shift_t;
    typedef logic [`RQ_FRAC_W-1:0]  frac_t;

    // lane vectors, element 0 is lane 0
    typedef acc_t   [`RQ_LANES-1:0] acc_vec_t;
    typedef coef_t  [`RQ_LANES-1:0] coef_vec_t;
    typedef prod_t  [`RQ_LANES-1:0] prod_vec_t;
    typedef out_t   [`RQ_LANES-1:0] out_vec_t;
    typedef shift_t [`RQ_LANES-1:0] shift_vec_t;

    // 1 picks the high window
    typedef logic [`RQ_LANES-1:0] sel_vec_t;

endpackage

/* include/rq_cfg.svh */
// requantization configuration
`ifndef RQ_CFG_SVH
`define RQ_CFG_SVH

// lane count
`define RQ_LANES    6

// datapath widths
`define RQ_ACC_W    22
`define RQ_COEF_W   9
`define RQ_PROD_W   18
`define RQ_OUT_W    8
`define RQ_SHIFT_W  4
`define RQ_FRAC_W   5

// window offsets into the accumulator
`define RQ_LO_OFS   8
`define RQ_HI_OFS   13

`endif
